// ==== verilog/cpu_pkg.sv ====
// widths, reset vector, opcode / alu / select encodings
// and the instruction word format views
package cpu_pkg;

  localparam int xlen = 32;                                 // data and address width
  localparam logic [xlen-1:0] reset_vector = 32'h0000_0000; // first fetch address

  typedef logic [4:0] reg_addr_t;

  // major opcodes handled by decode
  typedef enum logic [6:0] {
    opc_lui    = 7'b0110111,
    opc_op_imm = 7'b0010011,
    opc_op     = 7'b0110011,
    opc_load   = 7'b0000011,
    opc_store  = 7'b0100011,
    opc_branch = 7'b1100011,
    opc_jal    = 7'b1101111
  } opcode_e;

  typedef enum logic [3:0] {
    alu_add, alu_sub, alu_and, alu_or, alu_xor, alu_slt,
    alu_sltu, alu_sll, alu_srl, alu_sra, alu_pass_b
  } alu_op_e;

  typedef enum logic {opb_reg = 1'b0, opb_imm = 1'b1} alu_opb_e;

  typedef enum logic [1:0] {wb_alu = 2'd0, wb_load = 2'd1, wb_pc4 = 2'd2} wb_sel_e;

  // one 32 bit word, six ways to read it
  typedef struct packed {
    logic [6:0] funct7;
    reg_addr_t  rs2, rs1;
    logic [2:0] funct3;
    reg_addr_t  rd;
    logic [6:0] opcode;
  } instr_r_t;

  typedef struct packed {
    logic [11:0] imm;
    reg_addr_t   rs1;
    logic [2:0]  funct3;
    reg_addr_t   rd;
    logic [6:0]  opcode;
  } instr_i_t;

  typedef struct packed {
    logic [6:0] imm_11_5;
    reg_addr_t  rs2, rs1;
    logic [2:0] funct3;
    logic [4:0] imm_4_0;
    logic [6:0] opcode;
  } instr_s_t;

  typedef struct packed {
    logic       imm_12;
    logic [5:0] imm_10_5;
    reg_addr_t  rs2, rs1;
    logic [2:0] funct3;
    logic [3:0] imm_4_1;
    logic       imm_11;
    logic [6:0] opcode;
  } instr_b_t;

  typedef struct packed {
    logic [19:0] imm_31_12;
    reg_addr_t   rd;
    logic [6:0]  opcode;
  } instr_u_t;

  typedef struct packed {
    logic       imm_20;
    logic [9:0] imm_10_1;
    logic       imm_11;
    logic [7:0] imm_19_12;
    reg_addr_t  rd;
    logic [6:0] opcode;
  } instr_j_t;

  typedef union packed {
    instr_r_t r;
    instr_i_t i;
    instr_s_t s;
    instr_b_t b;
    instr_u_t u;
    instr_j_t j;
  } instr_u;

endpackage

// ==== verilog/cpu_fsm.sv ====
// stage sequencer with one flop per stage
// fetch -> decode -> exec -> (mem) -> wb
`timescale 1ns/100ps

module cpu_fsm (
  input  logic i_clk,
  input  logic i_rst_n,
  input  logic i_ibus_ack,
  input  logic i_dbus_ack,
  input  logic i_mem_access,   // decoded lw/sw
  output logic o_en_fetch,
  output logic o_en_decode,
  output logic o_en_exec,
  output logic o_en_mem,
  output logic o_en_wb
);

  logic st_fetch, st_decode, st_exec, st_mem, st_wb;

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      st_fetch  <= 1'b1; // start fetching at reset vector
      st_decode <= 1'b0;
      st_exec   <= 1'b0;
      st_mem    <= 1'b0;
      st_wb     <= 1'b0;
    end else begin
      st_fetch  <= (st_fetch & ~i_ibus_ack) | st_wb;        // wait for instr or start next one
      st_decode <= st_fetch & i_ibus_ack;
      st_exec   <= st_decode;                              // single cycle
      st_mem    <= (st_exec & i_mem_access) | (st_mem & ~i_dbus_ack);
      st_wb     <= (st_exec & ~i_mem_access) | (st_mem & i_dbus_ack);
    end
  end

  assign o_en_fetch  = st_fetch;
  assign o_en_decode = st_decode;
  assign o_en_exec   = st_exec;
  assign o_en_mem    = st_mem;
  assign o_en_wb     = st_wb;

  // exactly one stage active at any time
  a_one_stage: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    $onehot({st_fetch, st_decode, st_exec, st_mem, st_wb}));

endmodule

// ==== verilog/cpu_fetch.sv ====
// program counter, instruction bus master, instruction register
`timescale 1ns/100ps

module cpu_fetch (
  input  logic                    i_clk,
  input  logic                    i_rst_n,
  input  logic                    i_en_fetch,
  input  logic                    i_en_wb,
  input  logic [cpu_pkg::xlen-1:0] i_pc_next,      // from exec
  input  logic [cpu_pkg::xlen-1:0] i_ibus_rd_data,
  input  logic                    i_ibus_ack,
  output logic [cpu_pkg::xlen-1:0] o_ibus_addr,
  output logic                    o_ibus_rd_en,
  output logic [cpu_pkg::xlen-1:0] o_pc,
  output logic [cpu_pkg::xlen-1:0] o_instr
);

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      o_pc         <= cpu_pkg::reset_vector;
      o_ibus_rd_en <= 1'b0;
    end else begin
      if (i_en_wb) o_pc <= i_pc_next;                       // advance at end of instr
      o_ibus_rd_en <= i_en_fetch & ~(o_ibus_rd_en & i_ibus_ack); // drop after ack
    end
  end

  // instruction word, valid only in the ack cycle
  always_ff @(posedge i_clk) begin
    if (o_ibus_rd_en && i_ibus_ack) o_instr <= i_ibus_rd_data;
  end

  assign o_ibus_addr = o_pc;

  // pending read keeps its request and address until ack
  a_addr_hold: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    o_ibus_rd_en && !i_ibus_ack |=> o_ibus_rd_en && $stable(o_ibus_addr));

endmodule

// ==== verilog/cpu_decode.sv ====
// instruction decoder, immediates / register indexes / selects,
// all registered in the decode cycle
`timescale 1ns/100ps

module cpu_decode (
  input  logic                     i_clk,
  input  logic                     i_rst_n,
  input  logic                     i_en_decode,
  input  logic [cpu_pkg::xlen-1:0]  i_instr,
  output cpu_pkg::reg_addr_t       o_rs1,
  output cpu_pkg::reg_addr_t       o_rs2,
  output cpu_pkg::reg_addr_t       o_rd,
  output logic [cpu_pkg::xlen-1:0]  o_imm,
  output cpu_pkg::alu_op_e         o_alu_op,
  output cpu_pkg::alu_opb_e        o_alu_opb,
  output cpu_pkg::wb_sel_e         o_wb_sel,
  output logic                     o_rd_wr,       // instr writes rd
  output logic                     o_mem_access,
  output logic                     o_store,
  output logic                     o_branch,
  output logic [2:0]               o_branch_f3,
  output logic                     o_jal
);

  cpu_pkg::instr_u   ins;
  logic [31:0]       imm_i, imm_s, imm_b, imm_u, imm_j;
  logic [31:0]       imm_d;
  cpu_pkg::alu_op_e  alu_op_d;
  cpu_pkg::alu_opb_e opb_d;
  cpu_pkg::wb_sel_e  wb_d;
  logic              rd_wr_d, mem_d, store_d, branch_d, jal_d;

  // funct3 to alu op, alt picks sub / sra
  function automatic cpu_pkg::alu_op_e f3_op(input logic [2:0] f3, input logic alt);
    case (f3)
      3'b000:  f3_op = alt ? cpu_pkg::alu_sub : cpu_pkg::alu_add;
      3'b001:  f3_op = cpu_pkg::alu_sll;
      3'b010:  f3_op = cpu_pkg::alu_slt;
      3'b011:  f3_op = cpu_pkg::alu_sltu;
      3'b100:  f3_op = cpu_pkg::alu_xor;
      3'b101:  f3_op = alt ? cpu_pkg::alu_sra : cpu_pkg::alu_srl;
      3'b110:  f3_op = cpu_pkg::alu_or;
      default: f3_op = cpu_pkg::alu_and;
    endcase
  endfunction

  assign ins = i_instr;

  // sign extended immediates
  assign imm_i = {{20{ins.i.imm[11]}}, ins.i.imm};
  assign imm_s = {{20{ins.s.imm_11_5[6]}}, ins.s.imm_11_5, ins.s.imm_4_0};
  assign imm_b = {{19{ins.b.imm_12}}, ins.b.imm_12, ins.b.imm_11, ins.b.imm_10_5,
                  ins.b.imm_4_1, 1'b0};
  assign imm_u = {ins.u.imm_31_12, 12'b0};
  assign imm_j = {{11{ins.j.imm_20}}, ins.j.imm_20, ins.j.imm_19_12, ins.j.imm_11,
                  ins.j.imm_10_1, 1'b0};

  always_comb begin
    alu_op_d = cpu_pkg::alu_add; // address add for lw/sw
    opb_d    = cpu_pkg::opb_imm;
    wb_d     = cpu_pkg::wb_alu;
    imm_d    = imm_i;
    rd_wr_d  = 1'b0;             // unknown opcode: nop
    mem_d    = 1'b0;
    store_d  = 1'b0;
    branch_d = 1'b0;
    jal_d    = 1'b0;
    case (ins.r.opcode)
      cpu_pkg::opc_lui: begin
        alu_op_d = cpu_pkg::alu_pass_b;
        imm_d    = imm_u;
        rd_wr_d  = 1'b1;
      end
      cpu_pkg::opc_op_imm: begin // funct7 only matters for srai
        alu_op_d = f3_op(ins.r.funct3, ins.r.funct7[5] & (ins.r.funct3 == 3'b101));
        rd_wr_d  = 1'b1;
      end
      cpu_pkg::opc_op: begin
        alu_op_d = f3_op(ins.r.funct3, ins.r.funct7[5]);
        opb_d    = cpu_pkg::opb_reg;
        rd_wr_d  = 1'b1;
      end
      cpu_pkg::opc_load: begin
        wb_d    = cpu_pkg::wb_load;
        rd_wr_d = 1'b1;
        mem_d   = 1'b1;
      end
      cpu_pkg::opc_store: begin
        imm_d   = imm_s;
        mem_d   = 1'b1;
        store_d = 1'b1;
      end
      cpu_pkg::opc_branch: begin
        imm_d    = imm_b;
        branch_d = 1'b1;
      end
      cpu_pkg::opc_jal: begin
        imm_d   = imm_j;
        wb_d    = cpu_pkg::wb_pc4; // link
        rd_wr_d = 1'b1;
        jal_d   = 1'b1;
      end
      default: ;
    endcase
  end

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      o_rd_wr      <= 1'b0;
      o_mem_access <= 1'b0;
      o_store      <= 1'b0;
      o_branch     <= 1'b0;
      o_jal        <= 1'b0;
    end else if (i_en_decode) begin
      o_rd_wr      <= rd_wr_d & (ins.r.rd != 5'd0); // x0 never written
      o_mem_access <= mem_d;
      o_store      <= store_d;
      o_branch     <= branch_d;
      o_jal        <= jal_d;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_en_decode) begin
      o_rs1       <= ins.r.rs1;
      o_rs2       <= ins.r.rs2;
      o_rd        <= ins.r.rd;
      o_imm       <= imm_d;
      o_alu_op    <= alu_op_d;
      o_alu_opb   <= opb_d;
      o_wb_sel    <= wb_d;
      o_branch_f3 <= ins.b.funct3;
    end
  end

endmodule

// ==== verilog/cpu_regfile.sv ====
// 32 x 32 register file with two async read ports and one write port
`timescale 1ns/100ps

module cpu_regfile (
  input  logic                     i_clk,
  input  logic                     i_rst_n,
  input  cpu_pkg::reg_addr_t       i_rs1,
  input  cpu_pkg::reg_addr_t       i_rs2,
  output logic [cpu_pkg::xlen-1:0]  o_rs1_data,
  output logic [cpu_pkg::xlen-1:0]  o_rs2_data,
  input  logic                     i_wr_en,
  input  cpu_pkg::reg_addr_t       i_rd,
  input  logic [cpu_pkg::xlen-1:0]  i_wr_data
);

  logic [cpu_pkg::xlen-1:0] regs [32];

  always_ff @(posedge i_clk) begin
    if (i_wr_en && i_rd != 5'd0) regs[i_rd] <= i_wr_data; // x0 write dropped
  end

  // x0 reads as zero whatever the array holds
  assign o_rs1_data = (i_rs1 == 5'd0) ? '0 : regs[i_rs1];
  assign o_rs2_data = (i_rs2 == 5'd0) ? '0 : regs[i_rs2];

endmodule

// ==== verilog/cpu_exec.sv ====
// alu, branch compare and next pc, results registered in exec
`timescale 1ns/100ps

module cpu_exec (
  input  logic                     i_clk,
  input  logic                     i_rst_n,
  input  logic                     i_en_exec,
  input  logic [cpu_pkg::xlen-1:0]  i_pc,
  input  logic [cpu_pkg::xlen-1:0]  i_rs1_data,
  input  logic [cpu_pkg::xlen-1:0]  i_rs2_data,
  input  logic [cpu_pkg::xlen-1:0]  i_imm,
  input  cpu_pkg::alu_op_e         i_alu_op,
  input  cpu_pkg::alu_opb_e        i_alu_opb,
  input  logic                     i_branch,
  input  logic [2:0]               i_branch_f3,
  input  logic                     i_jal,
  output logic [cpu_pkg::xlen-1:0]  o_alu_out,
  output logic [cpu_pkg::xlen-1:0]  o_pc_next
);

  logic [cpu_pkg::xlen-1:0] opb, alu_res;
  logic [4:0]              shamt;
  logic                    eq, lt, taken;

  assign opb   = (i_alu_opb == cpu_pkg::opb_imm) ? i_imm : i_rs2_data;
  assign shamt = opb[4:0];

  always_comb begin
    case (i_alu_op)
      cpu_pkg::alu_add:    alu_res = i_rs1_data + opb;
      cpu_pkg::alu_sub:    alu_res = i_rs1_data - opb;
      cpu_pkg::alu_and:    alu_res = i_rs1_data & opb;
      cpu_pkg::alu_or:     alu_res = i_rs1_data | opb;
      cpu_pkg::alu_xor:    alu_res = i_rs1_data ^ opb;
      cpu_pkg::alu_slt:    alu_res = {31'b0, $signed(i_rs1_data) < $signed(opb)};
      cpu_pkg::alu_sltu:   alu_res = {31'b0, i_rs1_data < opb};
      cpu_pkg::alu_sll:    alu_res = i_rs1_data << shamt;
      cpu_pkg::alu_srl:    alu_res = i_rs1_data >> shamt;
      cpu_pkg::alu_sra:    alu_res = $signed(i_rs1_data) >>> shamt; // keeps sign
      cpu_pkg::alu_pass_b: alu_res = opb;                           // lui
      default:             alu_res = '0;
    endcase
  end

  // branch conditions always on the two registers
  assign eq = (i_rs1_data == i_rs2_data);
  assign lt = $signed(i_rs1_data) < $signed(i_rs2_data);

  always_comb begin
    case (i_branch_f3)
      3'b000:  taken = i_branch & eq;  // beq
      3'b001:  taken = i_branch & ~eq; // bne
      3'b100:  taken = i_branch & lt;  // blt
      3'b101:  taken = i_branch & ~lt; // bge
      default: taken = 1'b0;
    endcase
  end

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      o_alu_out <= '0;
      o_pc_next <= cpu_pkg::reset_vector;
    end else if (i_en_exec) begin
      o_alu_out <= alu_res;
      o_pc_next <= (taken || i_jal) ? i_pc + i_imm : i_pc + 32'd4;
    end
  end

endmodule

// ==== verilog/cpu_mem_wb.sv ====
// data bus master for lw/sw, load capture, write back mux
`timescale 1ns/100ps

module cpu_mem_wb (
  input  logic                     i_clk,
  input  logic                     i_rst_n,
  input  logic                     i_en_mem,
  input  logic                     i_en_wb,
  input  logic                     i_store,
  input  logic                     i_rd_wr,
  input  cpu_pkg::wb_sel_e         i_wb_sel,
  input  logic [cpu_pkg::xlen-1:0]  i_alu_out,      // effective address or result
  input  logic [cpu_pkg::xlen-1:0]  i_rs2_data,
  input  logic [cpu_pkg::xlen-1:0]  i_pc,
  input  logic [cpu_pkg::xlen-1:0]  i_dbus_rd_data,
  input  logic                     i_dbus_ack,
  output logic [cpu_pkg::xlen-1:0]  o_dbus_addr,
  output logic [3:0]               o_dbus_be,
  output logic                     o_dbus_wr_en,
  output logic [cpu_pkg::xlen-1:0]  o_dbus_wr_data,
  output logic                     o_dbus_rd_en,
  output logic                     o_rf_wr_en,
  output logic [cpu_pkg::xlen-1:0]  o_rf_wr_data
);

  logic                    req;     // transfer pending
  logic [cpu_pkg::xlen-1:0] load_q;

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) req <= 1'b0;
    else          req <= i_en_mem & ~(req & i_dbus_ack); // drop after ack
  end

  always_ff @(posedge i_clk) begin
    if (o_dbus_rd_en && i_dbus_ack) load_q <= i_dbus_rd_data;
  end

  // word access only, inputs stay put through mem
  assign o_dbus_addr    = {i_alu_out[31:2], 2'b00};
  assign o_dbus_be      = 4'hf;
  assign o_dbus_wr_data = i_rs2_data;
  assign o_dbus_wr_en   = req & i_store;
  assign o_dbus_rd_en   = req & ~i_store;

  always_comb begin
    case (i_wb_sel)
      cpu_pkg::wb_load: o_rf_wr_data = load_q;
      cpu_pkg::wb_pc4:  o_rf_wr_data = i_pc + 32'd4; // jal link
      default:          o_rf_wr_data = i_alu_out;
    endcase
  end

  assign o_rf_wr_en = i_en_wb & i_rd_wr;

endmodule

// ==== verilog/cpu_core.sv ====
// multi cycle rv32i core, stage instances and wiring
`timescale 1ns/100ps

module cpu_core (
  input  logic                    i_clk,
  input  logic                    i_rst_n,
  output logic [cpu_pkg::xlen-1:0] o_ibus_addr,
  output logic                    o_ibus_rd_en,
  input  logic [cpu_pkg::xlen-1:0] i_ibus_rd_data,
  input  logic                    i_ibus_ack,
  output logic [cpu_pkg::xlen-1:0] o_dbus_addr,
  output logic [3:0]              o_dbus_be,
  output logic                    o_dbus_wr_en,
  output logic [cpu_pkg::xlen-1:0] o_dbus_wr_data,
  output logic                    o_dbus_rd_en,
  input  logic [cpu_pkg::xlen-1:0] i_dbus_rd_data,
  input  logic                    i_dbus_ack
);

  logic                    en_fetch, en_decode, en_exec, en_mem, en_wb; // stage enables
  logic [cpu_pkg::xlen-1:0] pc, instr, pc_next, alu_out;
  cpu_pkg::reg_addr_t      rs1, rs2, rd;
  logic [cpu_pkg::xlen-1:0] imm, rs1_data, rs2_data;
  cpu_pkg::alu_op_e        alu_op;
  cpu_pkg::alu_opb_e       alu_opb;
  cpu_pkg::wb_sel_e        wb_sel;
  logic                    rd_wr, mem_access, store, branch, jal;
  logic [2:0]              branch_f3;
  logic                    rf_wr_en;
  logic [cpu_pkg::xlen-1:0] rf_wr_data;

  cpu_fsm fsm0 (
    .i_clk(i_clk), .i_rst_n(i_rst_n),
    .i_ibus_ack(i_ibus_ack), .i_dbus_ack(i_dbus_ack), .i_mem_access(mem_access),
    .o_en_fetch(en_fetch), .o_en_decode(en_decode), .o_en_exec(en_exec),
    .o_en_mem(en_mem), .o_en_wb(en_wb)
  );

  cpu_fetch fetch0 (
    .i_clk(i_clk), .i_rst_n(i_rst_n), .i_en_fetch(en_fetch), .i_en_wb(en_wb),
    .i_pc_next(pc_next), .i_ibus_rd_data(i_ibus_rd_data), .i_ibus_ack(i_ibus_ack),
    .o_ibus_addr(o_ibus_addr), .o_ibus_rd_en(o_ibus_rd_en), .o_pc(pc), .o_instr(instr)
  );

  cpu_decode decode0 (
    .i_clk(i_clk), .i_rst_n(i_rst_n), .i_en_decode(en_decode), .i_instr(instr),
    .o_rs1(rs1), .o_rs2(rs2), .o_rd(rd), .o_imm(imm),
    .o_alu_op(alu_op), .o_alu_opb(alu_opb), .o_wb_sel(wb_sel), .o_rd_wr(rd_wr),
    .o_mem_access(mem_access), .o_store(store), .o_branch(branch),
    .o_branch_f3(branch_f3), .o_jal(jal)
  );

  cpu_regfile regfile0 (
    .i_clk(i_clk), .i_rst_n(i_rst_n), .i_rs1(rs1), .i_rs2(rs2),
    .o_rs1_data(rs1_data), .o_rs2_data(rs2_data),
    .i_wr_en(rf_wr_en), .i_rd(rd), .i_wr_data(rf_wr_data)
  );

  cpu_exec exec0 (
    .i_clk(i_clk), .i_rst_n(i_rst_n), .i_en_exec(en_exec), .i_pc(pc),
    .i_rs1_data(rs1_data), .i_rs2_data(rs2_data), .i_imm(imm),
    .i_alu_op(alu_op), .i_alu_opb(alu_opb), .i_branch(branch),
    .i_branch_f3(branch_f3), .i_jal(jal), .o_alu_out(alu_out), .o_pc_next(pc_next)
  );

  cpu_mem_wb mem_wb0 (
    .i_clk(i_clk), .i_rst_n(i_rst_n), .i_en_mem(en_mem), .i_en_wb(en_wb),
    .i_store(store), .i_rd_wr(rd_wr), .i_wb_sel(wb_sel), .i_alu_out(alu_out),
    .i_rs2_data(rs2_data), .i_pc(pc), .i_dbus_rd_data(i_dbus_rd_data),
    .i_dbus_ack(i_dbus_ack), .o_dbus_addr(o_dbus_addr), .o_dbus_be(o_dbus_be),
    .o_dbus_wr_en(o_dbus_wr_en), .o_dbus_wr_data(o_dbus_wr_data),
    .o_dbus_rd_en(o_dbus_rd_en), .o_rf_wr_en(rf_wr_en), .o_rf_wr_data(rf_wr_data)
  );

endmodule

// ==== verif/tb_cpu_core.sv ====
// testbench for cpu_core with bus memory models and a program builder
// reference alu / branch functions, dbus store checker
`timescale 1ns/100ps

module tb_cpu_core;

  localparam logic [31:0] seed = 32'ha27c281e;
  localparam int max_cycles = 20000;   // per program run

  logic        i_clk, i_rst_n;
  logic [31:0] o_ibus_addr, i_ibus_rd_data;
  logic        o_ibus_rd_en, i_ibus_ack;
  logic [31:0] o_dbus_addr, o_dbus_wr_data, i_dbus_rd_data;
  logic [3:0]  o_dbus_be;
  logic        o_dbus_wr_en, o_dbus_rd_en, i_dbus_ack;

  logic [31:0] imem [1024];
  logic [31:0] dmem [256];
  logic [31:0] exp_addr [$];     // expected stores, in program order
  logic [31:0] exp_data [$];
  logic [31:0] irng, drng, orng; // lcg states: ibus delay, dbus delay, operands
  logic [31:0] orng_start;
  int          icnt, dcnt;       // cycles left until ack, 0 = idle
  bit          rand_delay;
  int          n_wr, errors, n_pass, n_fail;
  int          pc_w, st_idx;

  cpu_core dut0 (
    .i_clk(i_clk), .i_rst_n(i_rst_n),
    .o_ibus_addr(o_ibus_addr), .o_ibus_rd_en(o_ibus_rd_en),
    .i_ibus_rd_data(i_ibus_rd_data), .i_ibus_ack(i_ibus_ack),
    .o_dbus_addr(o_dbus_addr), .o_dbus_be(o_dbus_be), .o_dbus_wr_en(o_dbus_wr_en),
    .o_dbus_wr_data(o_dbus_wr_data), .o_dbus_rd_en(o_dbus_rd_en),
    .i_dbus_rd_data(i_dbus_rd_data), .i_dbus_ack(i_dbus_ack)
  );

  initial i_clk = 1'b0;
  always #20 i_clk = ~i_clk; // 40 ns period

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // 1..4 cycles when random, else ack in the cycle after the request
  function automatic int pick_delay(input logic [31:0] s);
    return rand_delay ? 1 + int'(s[17:16]) : 1;
  endfunction

  // instruction bus slave
  always @(posedge i_clk) begin
    if (!i_rst_n || i_ibus_ack) begin
      i_ibus_ack <= 1'b0;
      icnt = 0;
    end else if (o_ibus_rd_en) begin
      if (icnt == 0) begin
        irng = lcg_next(irng);
        icnt = pick_delay(irng);
      end
      icnt = icnt - 1;
      if (icnt == 0) begin
        i_ibus_ack     <= 1'b1;
        i_ibus_rd_data <= imem[o_ibus_addr[11:2]];
      end
    end
  end

  // data bus slave, word memory
  always @(posedge i_clk) begin
    if (!i_rst_n || i_dbus_ack) begin
      i_dbus_ack <= 1'b0;
      dcnt = 0;
    end else if (o_dbus_wr_en || o_dbus_rd_en) begin
      if (dcnt == 0) begin
        drng = lcg_next(drng);
        dcnt = pick_delay(drng);
      end
      dcnt = dcnt - 1;
      if (dcnt == 0) begin
        i_dbus_ack <= 1'b1;
        if (o_dbus_wr_en) dmem[o_dbus_addr[9:2]] <= o_dbus_wr_data;
        else              i_dbus_rd_data <= dmem[o_dbus_addr[9:2]];
      end
    end
  end

  // every completed store against the expected list
  always @(posedge i_clk) begin
    if (i_rst_n && o_dbus_wr_en && i_dbus_ack) begin
      if (n_wr >= exp_addr.size()) begin
        $display("unexpected extra store to address %h", o_dbus_addr);
        errors++;
      end else begin
        if (o_dbus_addr !== exp_addr[n_wr]) begin
          $display("** Error o_dbus_addr: expected %h, got %h", exp_addr[n_wr], o_dbus_addr);
          errors++;
        end
        if (o_dbus_wr_data !== exp_data[n_wr]) begin
          $display("** Error o_dbus_wr_data @%h: expected %h, got %h",
                   exp_addr[n_wr], exp_data[n_wr], o_dbus_wr_data);
          errors++;
        end
        if (o_dbus_be !== 4'hf) begin
          $display("** Error o_dbus_be: expected f, got %h", o_dbus_be);
          errors++;
        end
      end
      n_wr++;
    end
  end

  // expected alu result
  function automatic logic [31:0] ref_alu(input cpu_pkg::alu_op_e op,
                                          input logic [31:0] a, input logic [31:0] b);
    case (op)
      cpu_pkg::alu_add:    return a + b;
      cpu_pkg::alu_sub:    return a - b;
      cpu_pkg::alu_and:    return a & b;
      cpu_pkg::alu_or:     return a | b;
      cpu_pkg::alu_xor:    return a ^ b;
      cpu_pkg::alu_slt:    return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      cpu_pkg::alu_sltu:   return (a < b) ? 32'd1 : 32'd0;
      cpu_pkg::alu_sll:    return a << b[4:0];
      cpu_pkg::alu_srl:    return a >> b[4:0];
      cpu_pkg::alu_sra:    return $signed(a) >>> b[4:0];
      cpu_pkg::alu_pass_b: return b;
      default:             return 32'd0;
    endcase
  endfunction

  function automatic bit ref_branch(input logic [2:0] f3, input logic [31:0] a,
                                    input logic [31:0] b);
    case (f3)
      3'b000:  return a == b;
      3'b001:  return a != b;
      3'b100:  return $signed(a) < $signed(b);
      default: return $signed(a) >= $signed(b); // bge
    endcase
  endfunction

  // instruction encoders
  function automatic logic [31:0] enc_r(input logic [6:0] f7, input cpu_pkg::reg_addr_t rs2,
      input cpu_pkg::reg_addr_t rs1, input logic [2:0] f3, input cpu_pkg::reg_addr_t rd);
    cpu_pkg::instr_u w;
    w.r.funct7 = f7;
    w.r.rs2    = rs2;
    w.r.rs1    = rs1;
    w.r.funct3 = f3;
    w.r.rd     = rd;
    w.r.opcode = cpu_pkg::opc_op;
    return w;
  endfunction

  function automatic logic [31:0] enc_i(input logic [11:0] imm, input cpu_pkg::reg_addr_t rs1,
      input logic [2:0] f3, input cpu_pkg::reg_addr_t rd, input logic [6:0] op);
    cpu_pkg::instr_u w;
    w.i.imm    = imm;
    w.i.rs1    = rs1;
    w.i.funct3 = f3;
    w.i.rd     = rd;
    w.i.opcode = op;
    return w;
  endfunction

  function automatic logic [31:0] enc_s(input logic [11:0] imm, input cpu_pkg::reg_addr_t rs2,
      input cpu_pkg::reg_addr_t rs1);
    cpu_pkg::instr_u w;
    w.s.imm_11_5 = imm[11:5];
    w.s.rs2      = rs2;
    w.s.rs1      = rs1;
    w.s.funct3   = 3'b010; // sw
    w.s.imm_4_0  = imm[4:0];
    w.s.opcode   = cpu_pkg::opc_store;
    return w;
  endfunction

  function automatic logic [31:0] enc_b(input logic [12:0] imm, input cpu_pkg::reg_addr_t rs2,
      input cpu_pkg::reg_addr_t rs1, input logic [2:0] f3);
    cpu_pkg::instr_u w;
    w.b.imm_12   = imm[12];
    w.b.imm_10_5 = imm[10:5];
    w.b.rs2      = rs2;
    w.b.rs1      = rs1;
    w.b.funct3   = f3;
    w.b.imm_4_1  = imm[4:1];
    w.b.imm_11   = imm[11];
    w.b.opcode   = cpu_pkg::opc_branch;
    return w;
  endfunction

  function automatic logic [31:0] enc_u(input logic [19:0] imm, input cpu_pkg::reg_addr_t rd);
    cpu_pkg::instr_u w;
    w.u.imm_31_12 = imm;
    w.u.rd        = rd;
    w.u.opcode    = cpu_pkg::opc_lui;
    return w;
  endfunction

  function automatic logic [31:0] enc_j(input logic [20:0] imm, input cpu_pkg::reg_addr_t rd);
    cpu_pkg::instr_u w;
    w.j.imm_20    = imm[20];
    w.j.imm_10_1  = imm[10:1];
    w.j.imm_11    = imm[11];
    w.j.imm_19_12 = imm[19:12];
    w.j.rd        = rd;
    w.j.opcode    = cpu_pkg::opc_jal;
    return w;
  endfunction

  function automatic logic [31:0] next_operand();
    orng = lcg_next(orng);
    return orng;
  endfunction

  task automatic emit(input logic [31:0] w);
    imem[pc_w] = w;
    pc_w++;
  endtask

  task automatic start_program();
    pc_w   = 0;
    st_idx = 0;
    exp_addr.delete();
    exp_data.delete();
  endtask

  // lui + addi, upper part rounded for the signed low 12 bits
  task automatic load_const(input cpu_pkg::reg_addr_t rd, input logic [31:0] v);
    logic [31:0] hi;
    hi = v + 32'h800;
    emit(enc_u(hi[31:12], rd));
    emit(enc_i(v[11:0], rd, 3'b000, rd, cpu_pkg::opc_op_imm));
  endtask

  // sw to the next free result slot
  task automatic store_expect(input cpu_pkg::reg_addr_t rs, input logic [31:0] value);
    logic [31:0] addr;
    addr = 32'h100 + 32'(st_idx * 4);
    emit(enc_s(addr[11:0], rs, 5'd0));
    exp_addr.push_back(addr);
    exp_data.push_back(value);
    st_idx++;
  endtask

  task automatic build_reg_ops();
    logic [2:0] f3s [10] = '{3'd0, 3'd0, 3'd1, 3'd2, 3'd3, 3'd4, 3'd5, 3'd5, 3'd6, 3'd7};
    logic [6:0] f7s [10] = '{7'h00, 7'h20, 7'h00, 7'h00, 7'h00, 7'h00, 7'h00, 7'h20,
                             7'h00, 7'h00};
    cpu_pkg::alu_op_e ops [10] = '{cpu_pkg::alu_add, cpu_pkg::alu_sub, cpu_pkg::alu_sll,
        cpu_pkg::alu_slt, cpu_pkg::alu_sltu, cpu_pkg::alu_xor, cpu_pkg::alu_srl,
        cpu_pkg::alu_sra, cpu_pkg::alu_or, cpu_pkg::alu_and};
    logic [31:0] a, b;
    for (int p = 0; p < 3; p++) begin
      a = next_operand();
      b = next_operand();
      if (p == 2) begin // negative rs1 against positive rs2
        a = a | 32'h8000_0000;
        b = b & 32'h7fff_ffff;
      end
      load_const(5'd1, a);
      load_const(5'd2, b);
      for (int i = 0; i < 10; i++) begin
        emit(enc_r(f7s[i], 5'd2, 5'd1, f3s[i], 5'd3));
        store_expect(5'd3, ref_alu(ops[i], a, b));
      end
      emit(enc_u(a[31:12], 5'd4)); // plain lui
      store_expect(5'd4, ref_alu(cpu_pkg::alu_pass_b, 32'd0, {a[31:12], 12'h000}));
    end
  endtask

  task automatic build_imm_ops();
    logic [2:0] f3s [8] = '{3'd0, 3'd2, 3'd4, 3'd6, 3'd7, 3'd1, 3'd5, 3'd5};
    logic [6:0] hi7 [8] = '{7'h00, 7'h00, 7'h00, 7'h00, 7'h00, 7'h00, 7'h00, 7'h20};
    cpu_pkg::alu_op_e ops [8] = '{cpu_pkg::alu_add, cpu_pkg::alu_slt, cpu_pkg::alu_xor,
        cpu_pkg::alu_or, cpu_pkg::alu_and, cpu_pkg::alu_sll, cpu_pkg::alu_srl,
        cpu_pkg::alu_sra};
    logic [31:0] a, r;
    logic [11:0] imm;
    for (int p = 0; p < 2; p++) begin
      a = next_operand();
      r = next_operand();
      imm = r[11:0];
      if (p == 1) imm[11] = 1'b1; // negative immediate
      load_const(5'd1, a);
      for (int i = 0; i < 8; i++) begin
        if (i >= 5) imm = {hi7[i], r[24:20]}; // shifts use shamt only
        emit(enc_i(imm, 5'd1, f3s[i], 5'd3, cpu_pkg::opc_op_imm));
        store_expect(5'd3, ref_alu(ops[i], a, {{20{imm[11]}}, imm}));
      end
    end
  endtask

  task automatic build_ld_st();
    logic [31:0] v, slot;
    for (int p = 0; p < 2; p++) begin
      v = next_operand();
      load_const(5'd5, v);
      slot = 32'h100 + 32'(st_idx * 4);
      store_expect(5'd5, v);
      emit(enc_i(slot[11:0], 5'd0, 3'b010, 5'd6, cpu_pkg::opc_load)); // lw x6
      store_expect(5'd6, v);
    end
  endtask

  task automatic build_branches();
    logic [2:0]  f3s [4] = '{3'b000, 3'b001, 3'b100, 3'b101};
    logic [31:0] as [3] = '{32'd5, 32'hffff_fffd, 32'd7};
    logic [31:0] bs [3] = '{32'd5, 32'd7, 32'hffff_fffd};
    logic [31:0] link;
    for (int i = 0; i < 4; i++) begin
      for (int p = 0; p < 3; p++) begin
        load_const(5'd1, as[p]);
        load_const(5'd2, bs[p]);
        emit(enc_b(13'd12, 5'd2, 5'd1, f3s[i]));
        emit(enc_i(12'h0f0, 5'd0, 3'b000, 5'd7, cpu_pkg::opc_op_imm)); // fall marker
        emit(enc_j(21'd8, 5'd0));
        emit(enc_i(12'hfa5, 5'd0, 3'b000, 5'd7, cpu_pkg::opc_op_imm)); // taken marker
        store_expect(5'd7, ref_branch(f3s[i], as[p], bs[p]) ? 32'hffff_ffa5 : 32'h0000_00f0);
      end
    end
    link = 32'((pc_w + 1) * 4);
    emit(enc_j(21'd8, 5'd8));
    emit(enc_i(12'h001, 5'd0, 3'b000, 5'd9, cpu_pkg::opc_op_imm)); // skipped
    store_expect(5'd8, link);
  endtask

  // reset for 8 cycles, no bus request may show up meanwhile
  task automatic do_reset();
    @(posedge i_clk);
    i_rst_n <= 1'b0;
    repeat (8) begin
      @(posedge i_clk);
      if (o_ibus_rd_en || o_dbus_wr_en || o_dbus_rd_en) begin
        $display("bus request active during reset");
        errors++;
      end
    end
    i_rst_n <= 1'b1;
  endtask

  task automatic report_test(input string name, input int err0);
    if (errors == err0) begin
      n_pass++;
      $display("test %s: ok, %0d stores", name, n_wr);
    end else begin
      n_fail++;
      $display("test %s: failed with %0d errors", name, errors - err0);
    end
  endtask

  task automatic run_program(input string name);
    int cyc;
    int err0;
    err0 = errors;
    emit(enc_j(21'd0, 5'd0)); // halt loop
    n_wr = 0;
    do_reset();
    cyc = 0;
    while (n_wr < exp_addr.size() && cyc < max_cycles) begin
      @(posedge i_clk);
      cyc++;
    end
    if (n_wr < exp_addr.size()) begin
      $display("%s: timeout, only %0d of %0d stores seen", name, n_wr, exp_addr.size());
      errors++;
    end else begin
      repeat (50) @(posedge i_clk); // catch late extra stores
    end
    report_test(name, err0);
  endtask

  task automatic check_reset_fetch();
    int cyc;
    int err0;
    err0 = errors;
    start_program();
    emit(enc_j(21'd0, 5'd0));
    n_wr = 0;
    do_reset();
    cyc = 0;
    while (!o_ibus_rd_en && cyc < 100) begin
      @(posedge i_clk);
      if (o_dbus_wr_en || o_dbus_rd_en) begin
        $display("data bus request before the first fetch");
        errors++;
      end
      cyc++;
    end
    if (!o_ibus_rd_en) begin
      $display("no instruction fetch after reset");
      errors++;
    end else if (o_ibus_addr !== cpu_pkg::reset_vector) begin
      $display("** Error o_ibus_addr: expected %h, got %h", cpu_pkg::reset_vector, o_ibus_addr);
      errors++;
    end
    report_test("reset_fetch", err0);
  endtask

  initial begin
    i_rst_n        = 1'b0;
    i_ibus_ack     = 1'b0;
    i_ibus_rd_data = 32'd0;
    i_dbus_ack     = 1'b0;
    i_dbus_rd_data = 32'd0;
    irng = seed;
    drng = lcg_next(seed ^ 32'h5555_5555);
    orng = lcg_next(seed ^ 32'haaaa_aaaa);
    icnt = 0;
    dcnt = 0;
    rand_delay = 1'b0;
    errors = 0;
    n_pass = 0;
    n_fail = 0;

    check_reset_fetch();
    orng_start = orng;
    start_program();
    build_reg_ops();
    run_program("reg_reg_ops");
    start_program();
    build_imm_ops();
    run_program("imm_ops");
    start_program();
    build_ld_st();
    run_program("load_store");
    start_program();
    build_branches();
    run_program("branch_jal");

    // same operands again, all in one program, random ack delays
    orng = orng_start;
    rand_delay = 1'b1;
    start_program();
    build_reg_ops();
    build_imm_ops();
    build_ld_st();
    build_branches();
    run_program("random_delays");

    $display("%0d tests passed, %0d failed, %0d errors", n_pass, n_fail, errors);
    if (errors == 0 && n_fail == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

// ==== build.f ====
verilog/cpu_pkg.sv
verilog/cpu_fsm.sv
verilog/cpu_fetch.sv
verilog/cpu_decode.sv
verilog/cpu_regfile.sv
verilog/cpu_exec.sv
verilog/cpu_mem_wb.sv
verilog/cpu_core.sv
verif/tb_cpu_core.sv

// ==== Makefile ====
VERILATOR  ?= verilator
SIM_FLAGS  := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only --timing
TOP        := tb_cpu_core
RTL_TOP    := cpu_core
FILELIST   := build.f
PASS_MSG   := *** TEST PASSED ***

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -F '$(PASS_MSG)' > /dev/null

clean:
	rm -rf obj_dir
